// ==== design/RiscvPkg.sv ====
package RiscvPkg;

    localparam int XLEN       = 32;                 // Data and address width
    localparam int REG_ADDR_W = 5;                  // Register index width
    localparam int NUM_REGS   = 2 ** REG_ADDR_W;
    localparam int BYTE_W     = 8;                  // Memory accesses are byte-wide
    localparam int SHAMT_W    = 5;                  // Shift amount bits taken from operand B

    // Instruction field positions
    localparam int OPCODE_LSB = 0;
    localparam int OPCODE_W   = 7;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_W   = 3;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_BIT = 30;                 // Only the SUB/SRA bit is decoded

    typedef enum logic [6:0] {
        TypeR     = 7'b0110011,                     // Register ALU ops
        TypeILoad = 7'b0000011,                     // Loads
        TypeIAlu  = 7'b0010011,                     // Immediate ALU ops
        TypeS     = 7'b0100011,                     // Stores
        TypeB     = 7'b1100011,                     // Branches
        TypeU     = 7'b0010111,                     // AUIPC
        TypeULui  = 7'b0110111,                     // LUI
        TypeJJalr = 7'b1100111,
        TypeJJal  = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        AluAdd       = 4'b0000,
        AluBne       = 4'b0001,
        AluJal       = 4'b0010,
        AluJalr      = 4'b0011,
        AluLui       = 4'b0100,
        AluLoadByte  = 4'b0101,
        AluStoreByte = 4'b0110,
        AluSll       = 4'b0111,
        AluSub       = 4'b1000,
        AluSrl       = 4'b1001,
        AluXor       = 4'b1010,
        AluOr        = 4'b1011,
        AluAnd       = 4'b1100,
        AluBeq       = 4'b1101
    } aluOp_e;

    typedef enum logic [2:0] {
        ImmI = 3'b000,
        ImmU = 3'b001,
        ImmS = 3'b010,
        ImmB = 3'b011,
        ImmJ = 3'b100
    } immSrc_e;

    localparam logic [2:0] FUNCT3_BEQ = 3'b000;
    localparam logic [2:0] FUNCT3_BNE = 3'b001;

endpackage

// ==== design/CtrlIf.sv ====
`timescale 1ns/1ps

interface CtrlIf (
    input logic rst
);
    logic               regWrite;               // Register file write enable
    RiscvPkg::aluOp_e   aluCtrl;
    logic               aluSrc;                 // Operand B is the immediate
    logic               aluSrcPc;               // Operand A is the PC (AUIPC)
    RiscvPkg::immSrc_e  immSrc;
    logic               memWrite;               // Byte store enable
    logic               resultSrc;              // Write back the load byte
    logic               jumpSrc;                // JAL
    logic               jRetSrc;                // JALR
    logic               beq;
    logic               bne;
    logic               memType;                // Load or store in flight

    modport decoder (
        input  rst,
        output regWrite, aluCtrl, aluSrc, aluSrcPc, immSrc, memWrite,
        output resultSrc, jumpSrc, jRetSrc, beq, bne, memType
    );

    modport datapath (
        input regWrite, aluCtrl, aluSrc, aluSrcPc, immSrc,
        input resultSrc, jumpSrc, jRetSrc, memType
    );

    modport pc (
        input jumpSrc, jRetSrc, beq, bne
    );

endinterface

// ==== design/ControlUnit.sv ====
`timescale 1ns/1ps

module ControlUnit (
    input  logic [6:0]  opcode,
    input  logic [2:0]  funct3,
    input  logic        funct7,
    CtrlIf.decoder      ctrl
);
    RiscvPkg::opcode_e  op;
    logic [1:0]         opFunct7;               // R-type bit and funct7 together
    logic               isAluR;
    logic               isAluI;
    logic               isLoad;
    logic               isStore;
    logic               isBranch;
    logic               isAuipc;
    logic               isLui;
    logic               isJal;
    logic               isJalr;

    assign op       = RiscvPkg::opcode_e'(opcode);
    assign opFunct7 = {opcode[5], funct7};

    assign isAluR   = (op == RiscvPkg::TypeR);
    assign isAluI   = (op == RiscvPkg::TypeIAlu);
    assign isLoad   = (op == RiscvPkg::TypeILoad);
    assign isStore  = (op == RiscvPkg::TypeS);
    assign isBranch = (op == RiscvPkg::TypeB);
    assign isAuipc  = (op == RiscvPkg::TypeU);
    assign isLui    = (op == RiscvPkg::TypeULui);
    assign isJal    = (op == RiscvPkg::TypeJJal);
    assign isJalr   = (op == RiscvPkg::TypeJJalr);

    assign ctrl.regWrite  = isAluR | isAluI | isLoad | isAuipc | isLui | isJal | isJalr;
    assign ctrl.aluSrc    = isAluI | isLoad | isStore | isAuipc | isLui | isJalr;
    assign ctrl.aluSrcPc  = isAuipc;
    assign ctrl.memWrite  = isStore & ~ctrl.rst;    // No stores while in reset
    assign ctrl.resultSrc = isLoad;
    assign ctrl.jumpSrc   = isJal;
    assign ctrl.jRetSrc   = isJalr;
    assign ctrl.beq       = isBranch & (funct3 == RiscvPkg::FUNCT3_BEQ);
    assign ctrl.bne       = isBranch & (funct3 == RiscvPkg::FUNCT3_BNE);
    assign ctrl.memType   = isLoad | isStore;

    always_comb begin
        ctrl.aluCtrl = RiscvPkg::AluAdd;
        ctrl.immSrc  = RiscvPkg::ImmI;
        case (op)
            RiscvPkg::TypeR, RiscvPkg::TypeIAlu: begin
                case (funct3)
                    3'b000: begin
                        if (opFunct7 == 2'b11) begin
                            ctrl.aluCtrl = RiscvPkg::AluSub;    // R-type only, no SUBI
                        end else begin
                            ctrl.aluCtrl = RiscvPkg::AluAdd;
                        end
                    end
                    3'b001:  ctrl.aluCtrl = RiscvPkg::AluSll;
                    3'b100:  ctrl.aluCtrl = RiscvPkg::AluXor;
                    3'b101:  ctrl.aluCtrl = RiscvPkg::AluSrl;  // Always logical
                    3'b110:  ctrl.aluCtrl = RiscvPkg::AluOr;
                    3'b111:  ctrl.aluCtrl = RiscvPkg::AluAnd;
                    default: ctrl.aluCtrl = RiscvPkg::AluAdd;
                endcase
            end
            RiscvPkg::TypeILoad: begin
                ctrl.aluCtrl = RiscvPkg::AluLoadByte;   // Every load is byte-wide
            end
            RiscvPkg::TypeS: begin
                ctrl.immSrc  = RiscvPkg::ImmS;
                ctrl.aluCtrl = RiscvPkg::AluStoreByte;
            end
            RiscvPkg::TypeB: begin
                ctrl.immSrc = RiscvPkg::ImmB;
                case (funct3)
                    RiscvPkg::FUNCT3_BEQ: ctrl.aluCtrl = RiscvPkg::AluBeq;
                    RiscvPkg::FUNCT3_BNE: ctrl.aluCtrl = RiscvPkg::AluBne;
                    default: ;                          // Falls through as a no-op
                endcase
            end
            RiscvPkg::TypeU: begin
                ctrl.immSrc  = RiscvPkg::ImmU;
                ctrl.aluCtrl = RiscvPkg::AluAdd;        // PC plus upper immediate
            end
            RiscvPkg::TypeULui: begin
                ctrl.immSrc  = RiscvPkg::ImmU;
                ctrl.aluCtrl = RiscvPkg::AluLui;
            end
            RiscvPkg::TypeJJal: begin
                ctrl.immSrc  = RiscvPkg::ImmJ;
                ctrl.aluCtrl = RiscvPkg::AluJal;
            end
            RiscvPkg::TypeJJalr: begin
                ctrl.immSrc  = RiscvPkg::ImmI;
                ctrl.aluCtrl = RiscvPkg::AluJalr;       // rs1 plus offset
            end
            default: ;
        endcase
    end

endmodule

// ==== design/ImmExtend.sv ====
`timescale 1ns/1ps

module ImmExtend (
    input  logic [31:0]         instr,
    input  RiscvPkg::immSrc_e   immSrc,
    output logic [31:0]         imm
);

    always_comb begin
        case (immSrc)
            RiscvPkg::ImmI: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            RiscvPkg::ImmU: begin
                imm = {instr[31:12], 12'b0};                        // Upper 20 bits
            end
            RiscvPkg::ImmS: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            RiscvPkg::ImmB: begin
                imm = {{19{instr[31]}}, instr[31], instr[7],
                       instr[30:25], instr[11:8], 1'b0};            // Halfword offset
            end
            RiscvPkg::ImmJ: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12],
                       instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// ==== design/RegFile.sv ====
`timescale 1ns/1ps

module RegFile (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [RiscvPkg::REG_ADDR_W-1:0] rs1Addr,
    input  logic [RiscvPkg::REG_ADDR_W-1:0] rs2Addr,
    input  logic [RiscvPkg::REG_ADDR_W-1:0] rdAddr,
    input  logic [RiscvPkg::XLEN-1:0]       rdData,
    input  logic                            wrEn,
    output logic [RiscvPkg::XLEN-1:0]       rs1Data,
    output logic [RiscvPkg::XLEN-1:0]       rs2Data
);
    logic [RiscvPkg::XLEN-1:0] regs [RiscvPkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RiscvPkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (rdAddr != '0)) begin    // x0 never written
            regs[rdAddr] <= rdData;
        end
    end

    // Asynchronous reads with x0 forced to zero
    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

// ==== design/Alu.sv ====
`timescale 1ns/1ps

module Alu (
    input  logic [RiscvPkg::XLEN-1:0]   a,
    input  logic [RiscvPkg::XLEN-1:0]   b,
    input  RiscvPkg::aluOp_e            aluCtrl,
    output logic [RiscvPkg::XLEN-1:0]   result,
    output logic                        zero
);
    logic [RiscvPkg::SHAMT_W-1:0] shamt;

    assign shamt = b[RiscvPkg::SHAMT_W-1:0];

    always_comb begin
        case (aluCtrl)
            RiscvPkg::AluAdd,
            RiscvPkg::AluLoadByte,
            RiscvPkg::AluStoreByte,
            RiscvPkg::AluJal,
            RiscvPkg::AluJalr: begin
                result = a + b;                 // Sums and address generation
            end
            RiscvPkg::AluSub,
            RiscvPkg::AluBeq,
            RiscvPkg::AluBne: begin
                result = a - b;                 // Branches compare through zero
            end
            RiscvPkg::AluSll: result = a << shamt;
            RiscvPkg::AluSrl: result = a >> shamt;
            RiscvPkg::AluXor: result = a ^ b;
            RiscvPkg::AluOr:  result = a | b;
            RiscvPkg::AluAnd: result = a & b;
            RiscvPkg::AluLui: result = b;       // Immediate passes through
            default:          result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== design/PcUnit.sv ====
`timescale 1ns/1ps

module PcUnit (
    input  logic                        clk,
    input  logic                        rst,
    CtrlIf.pc                           ctrl,
    input  logic [RiscvPkg::XLEN-1:0]   imm,
    input  logic                        aluZero,
    input  logic [RiscvPkg::XLEN-1:0]   aluResult,
    output logic [RiscvPkg::XLEN-1:0]   pc
);
    logic [RiscvPkg::XLEN-1:0] pcImm;         // Branch and JAL target
    logic [RiscvPkg::XLEN-1:0] pcPlus4;
    logic [RiscvPkg::XLEN-1:0] pcNext;
    logic                      takeBranch;

    assign pcImm      = pc + imm;
    assign pcPlus4    = pc + 32'd4;
    assign takeBranch = (ctrl.beq & aluZero) | (ctrl.bne & ~aluZero);

    always_comb begin
        if (ctrl.jRetSrc) begin
            pcNext = {aluResult[RiscvPkg::XLEN-1:1], 1'b0};   // JALR clears bit 0
        end else if (ctrl.jumpSrc || takeBranch) begin
            pcNext = pcImm;
        end else begin
            pcNext = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

// ==== design/Datapath.sv ====
`timescale 1ns/1ps

module Datapath (
    input  logic                            clk,
    input  logic                            rst,
    CtrlIf.datapath                         ctrl,
    input  logic [31:0]                     instr,
    input  logic [RiscvPkg::XLEN-1:0]       pc,
    input  logic [RiscvPkg::BYTE_W-1:0]     dmemRdData,
    output logic [RiscvPkg::XLEN-1:0]       imm,
    output logic [RiscvPkg::XLEN-1:0]       aluResult,
    output logic [RiscvPkg::BYTE_W-1:0]     dmemWrData,
    output logic                            aluZero
);
    logic [RiscvPkg::REG_ADDR_W-1:0] rs1Addr;
    logic [RiscvPkg::REG_ADDR_W-1:0] rs2Addr;
    logic [RiscvPkg::REG_ADDR_W-1:0] rdAddr;
    logic [RiscvPkg::XLEN-1:0]       rs1Data;
    logic [RiscvPkg::XLEN-1:0]       rs2Data;
    logic [RiscvPkg::XLEN-1:0]       srcA;
    logic [RiscvPkg::XLEN-1:0]       srcB;
    logic [RiscvPkg::XLEN-1:0]       loadData;
    logic [RiscvPkg::XLEN-1:0]       wbData;
    logic                            regWrEn;

    assign rs1Addr = instr[RiscvPkg::RS1_LSB +: RiscvPkg::REG_ADDR_W];
    assign rs2Addr = instr[RiscvPkg::RS2_LSB +: RiscvPkg::REG_ADDR_W];
    assign rdAddr  = instr[RiscvPkg::RD_LSB +: RiscvPkg::REG_ADDR_W];

    assign srcA    = ctrl.aluSrcPc ? pc : rs1Data;     // PC for AUIPC
    assign srcB    = ctrl.aluSrc ? imm : rs2Data;
    assign regWrEn = ctrl.regWrite & ~rst;

    // Load byte is zero-extended
    assign loadData   = {{(RiscvPkg::XLEN - RiscvPkg::BYTE_W){1'b0}}, dmemRdData};
    assign dmemWrData = ctrl.memType ? rs2Data[RiscvPkg::BYTE_W-1:0] : '0;

    always_comb begin
        if (ctrl.jumpSrc || ctrl.jRetSrc) begin
            wbData = pc + 32'd4;                        // Link address
        end else if (ctrl.resultSrc) begin
            wbData = loadData;
        end else begin
            wbData = aluResult;
        end
    end

    RegFile uRegFile (
        .clk     (clk),
        .rst     (rst),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rdAddr  (rdAddr),
        .rdData  (wbData),
        .wrEn    (regWrEn),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    ImmExtend uImmExtend (
        .instr  (instr),
        .immSrc (ctrl.immSrc),
        .imm    (imm)
    );

    Alu uAlu (
        .a       (srcA),
        .b       (srcB),
        .aluCtrl (ctrl.aluCtrl),
        .result  (aluResult),
        .zero    (aluZero)
    );

endmodule

// ==== design/RiscvCore.sv ====
`timescale 1ns/1ps

module RiscvCore (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [31:0]                     imemData,   // Instruction at imemAddr
    input  logic [RiscvPkg::BYTE_W-1:0]     dmemRdData,
    output logic [RiscvPkg::XLEN-1:0]       imemAddr,
    output logic [RiscvPkg::XLEN-1:0]       dmemAddr,
    output logic [RiscvPkg::BYTE_W-1:0]     dmemWrData,
    output logic                            dmemWrEn
);
    logic [RiscvPkg::XLEN-1:0] pc;
    logic [RiscvPkg::XLEN-1:0] imm;
    logic [RiscvPkg::XLEN-1:0] aluResult;
    logic                      aluZero;

    CtrlIf ctrl (
        .rst (rst)
    );

    ControlUnit uControlUnit (
        .opcode (imemData[RiscvPkg::OPCODE_LSB +: RiscvPkg::OPCODE_W]),
        .funct3 (imemData[RiscvPkg::FUNCT3_LSB +: RiscvPkg::FUNCT3_W]),
        .funct7 (imemData[RiscvPkg::FUNCT7_BIT]),
        .ctrl   (ctrl.decoder)
    );

    Datapath uDatapath (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl.datapath),
        .instr      (imemData),
        .pc         (pc),
        .dmemRdData (dmemRdData),
        .imm        (imm),
        .aluResult  (aluResult),
        .dmemWrData (dmemWrData),
        .aluZero    (aluZero)
    );

    PcUnit uPcUnit (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl.pc),
        .imm       (imm),
        .aluZero   (aluZero),
        .aluResult (aluResult),
        .pc        (pc)
    );

    assign imemAddr = pc;
    assign dmemAddr = aluResult;            // Byte address from the ALU
    assign dmemWrEn = ctrl.memWrite;

endmodule

// ==== bench/Core_assert.sv ====
`timescale 1ns/1ps

module Core_assert (
    input logic        clk,
    input logic        rst,
    input logic [31:0] imemAddr,
    input logic        dmemWrEn
);
    int failCount = 0;

    noStoreInReset: assert property (@(posedge clk) rst |-> !dmemWrEn)
        else begin
            $error("dmemWrEn asserted while rst is high");
            failCount++;
        end

    pcAligned: assert property (@(posedge clk) disable iff (rst) imemAddr[1:0] == 2'b00)
        else begin
            $error("imemAddr is not word-aligned");
            failCount++;
        end

    startAtZero: assert property (@(posedge clk) $fell(rst) |-> imemAddr == 32'd0)
        else begin
            $error("imemAddr is not zero after reset");
            failCount++;
        end

endmodule

// ==== bench/CoreChecker.sv ====
`timescale 1ns/1ps

module CoreChecker (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] imemData,
    input  logic [31:0] imemAddr,
    input  logic [31:0] dmemAddr,
    input  logic [7:0]  dmemWrData,
    input  logic        dmemWrEn,
    input  logic [31:0] endAddr,
    output logic        done,
    output int          errorCount
);
    logic [31:0] mPc;
    logic [31:0] mRegs [32];
    logic [7:0]  mMem [256];
    logic        expStore;
    logic [31:0] expAddr;
    logic [7:0]  expData;
    logic        finished = 1'b0;
    int          errs = 0;

    assign done       = finished;
    assign errorCount = errs;

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            errs++;
        end
    endtask

    function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic subBit,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return subBit ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];       // Logical even with bit 30 set
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return a + b;
        endcase
    endfunction

    // Retires one instruction on the architectural state
    function automatic void stepModel(input logic [31:0] instr);
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immJ;
        logic [31:0] immU;
        logic [31:0] res;
        logic [31:0] nextPc;
        logic        wr;
        rd     = instr[11:7];
        f3     = instr[14:12];
        a      = mRegs[instr[19:15]];
        b      = mRegs[instr[24:20]];
        immI   = {{20{instr[31]}}, instr[31:20]};
        immS   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        immB   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        immJ   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        immU   = {instr[31:12], 12'b0};
        res    = '0;
        wr     = 1'b1;
        nextPc = mPc + 32'd4;
        expStore = 1'b0;
        expAddr  = '0;
        expData  = '0;
        case (instr[6:0])
            RiscvPkg::TypeR:     res = refAlu(f3, instr[30], a, b);
            RiscvPkg::TypeIAlu:  res = refAlu(f3, 1'b0, a, immI);   // No SUBI
            RiscvPkg::TypeILoad: res = {24'b0, mMem[8'(a + immI)]};
            RiscvPkg::TypeULui:  res = immU;
            RiscvPkg::TypeU:     res = mPc + immU;
            RiscvPkg::TypeS: begin
                wr       = 1'b0;
                expStore = 1'b1;
                expAddr  = a + immS;
                expData  = b[7:0];
                mMem[expAddr[7:0]] = b[7:0];
            end
            RiscvPkg::TypeB: begin
                wr = 1'b0;
                if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
                    nextPc = mPc + immB;
                end
            end
            RiscvPkg::TypeJJal: begin
                res    = mPc + 32'd4;
                nextPc = mPc + immJ;
            end
            RiscvPkg::TypeJJalr: begin
                res    = mPc + 32'd4;
                nextPc = (a + immI) & ~32'd1;   // Target taken before rd is written
            end
            default: wr = 1'b0;
        endcase
        if (wr && rd != 5'd0) begin
            mRegs[rd] = res;
        end
        mPc = nextPc;
    endfunction

    always @(negedge clk) begin
        if (rst) begin
            mPc = '0;
            for (int i = 0; i < 32; i++) begin
                mRegs[i] = '0;
            end
            for (int i = 0; i < 256; i++) begin
                mMem[i] = '0;
            end
            checkValue("dmemWrEn", 32'(dmemWrEn), 32'd0);
        end else begin
            checkValue("imemAddr", imemAddr, mPc);
            if (mPc == endAddr) begin
                finished = 1'b1;
            end
            stepModel(imemData);
            checkValue("dmemWrEn", 32'(dmemWrEn), 32'(expStore));
            if (expStore) begin
                checkValue("dmemAddr", dmemAddr, expAddr);
                checkValue("dmemWrData", 32'(dmemWrData), 32'(expData));
            end
        end
    end

endmodule

// ==== bench/CoreTb.sv ====
`timescale 1ns/1ps

module CoreTb;

    localparam int          PROG_WORDS   = 64;
    localparam int          CLK_PERIOD   = 10;
    localparam int          RESET_CYCLES = 4;
    localparam int          DRIVE_DELAY  = 1;
    localparam int          WATCHDOG_NS  = PROG_WORDS * 40 * CLK_PERIOD;
    localparam logic [31:0] NOP          = 32'h0000_0013;   // ADDI x0, x0, 0
    localparam logic [31:0] FIRST_WORD   = 32'h0000_0023;   // SB x0, 0(x0) held through reset
    localparam logic [31:0] END_ADDR     = 32'((PROG_WORDS - 1) * 4);

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic [31:0] imemData = NOP;
    logic [7:0]  dmemRdData;
    logic [31:0] imemAddr;
    logic [31:0] dmemAddr;
    logic [7:0]  dmemWrData;
    logic        dmemWrEn;
    logic        done;
    int          errorCount;
    int          totalErrors;

    logic [31:0] prog [PROG_WORDS];
    logic [7:0]  dmem [256];
    logic [31:0] lfsr;

    always #(CLK_PERIOD / 2) clk = ~clk;

    RiscvCore i_dut (
        .clk        (clk),
        .rst        (rst),
        .imemData   (imemData),
        .dmemRdData (dmemRdData),
        .imemAddr   (imemAddr),
        .dmemAddr   (dmemAddr),
        .dmemWrData (dmemWrData),
        .dmemWrEn   (dmemWrEn)
    );

    bind RiscvCore Core_assert uCoreAssert (
        .clk      (clk),
        .rst      (rst),
        .imemAddr (imemAddr),
        .dmemWrEn (dmemWrEn)
    );

    CoreChecker uChecker (
        .clk        (clk),
        .rst        (rst),
        .imemData   (imemData),
        .imemAddr   (imemAddr),
        .dmemAddr   (dmemAddr),
        .dmemWrData (dmemWrData),
        .dmemWrEn   (dmemWrEn),
        .endAddr    (END_ADDR),
        .done       (done),
        .errorCount (errorCount)
    );

    // Word-indexed instruction memory
    always @(posedge clk) begin
        #(DRIVE_DELAY);
        imemData <= prog[imemAddr[7:2]];
    end

    // Byte-wide data memory cleared in reset
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= 8'h00;
            end
        end else if (dmemWrEn) begin
            dmem[dmemAddr[7:0]] <= dmemWrData;
        end
    end

    assign dmemRdData = dmem[dmemAddr[7:0]];

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic logic [2:0] aluFunct3(input logic [2:0] sel);
        case (sel)
            3'd1:    return 3'b001;
            3'd2:    return 3'b100;
            3'd3:    return 3'b101;
            3'd4:    return 3'b110;
            3'd5:    return 3'b111;
            default: return 3'b000;                 // ADD/SUB more often
        endcase
    endfunction

    // One random instruction at word index idx with forward jumps only
    function automatic logic [31:0] makeInstr(input int idx);
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  memBase;
        logic [2:0]  f3;
        logic [11:0] imm12;
        logic [11:0] memOff;
        logic [31:0] off;
        logic [31:0] tgt;
        int          room;
        kind    = 4'(takeBits(4));
        rd      = {2'b00, 3'(takeBits(3))};         // x0..x7 for more reuse
        rs1     = {2'b00, 3'(takeBits(3))};
        rs2     = {2'b00, 3'(takeBits(3))};
        memBase = takeBits(1) == 32'd1 ? 5'd0 : rs1;
        f3      = aluFunct3(3'(takeBits(3)));
        imm12   = 12'(takeBits(12));
        memOff  = 12'(takeBits(4));
        room    = PROG_WORDS - 1 - idx;
        off     = 32'(4 * (1 + (int'(takeBits(2)) % ((room < 4) ? room : 4))));
        tgt     = 32'(4 * idx) + off;
        case (kind)
            4'd0, 4'd1, 4'd2:
                return {1'b0, 1'(takeBits(1)), 5'b0, rs2, rs1, f3, rd, 7'b0110011};
            4'd3, 4'd4:
                return {imm12, rs1, f3, rd, 7'b0010011};
            4'd5:
                return {memOff, memBase, 3'b100, rd, 7'b0000011};
            4'd6, 4'd7, 4'd15:
                return {memOff[11:5], rs2, memBase, 3'b000, memOff[4:0], 7'b0100011};
            4'd8:
                return {1'b0, off[10:5], rs2, rs1, 2'b00, 1'(takeBits(1)),
                        off[4:1], off[11], 7'b1100011};
            4'd9:                                   // Branch funct3 outside BEQ/BNE
                return {1'b0, off[10:5], rs2, rs1, 1'b1, 2'(takeBits(2)),
                        off[4:1], off[11], 7'b1100011};
            4'd10:
                return {20'(takeBits(20)), rd, 7'b0110111};
            4'd11:
                return {20'(takeBits(20)), rd, 7'b0010111};
            4'd12:
                return {1'b0, off[10:1], off[11], off[19:12], rd, 7'b1101111};
            4'd13:                                  // Bit 0 of the target may be set
                return {tgt[11:1], 1'(takeBits(1)), 5'd0, 3'b000, rd, 7'b1100111};
            default:                                // Unknown opcode
                return {25'(takeBits(25)), 7'b0001011};
        endcase
    endfunction

    initial begin
        lfsr    = 32'h625c_efa1;
        prog[0] = FIRST_WORD;                       // Store on the bus while rst is high
        for (int i = 1; i < PROG_WORDS - 1; i++) begin
            prog[i] = makeInstr(i);
        end
        prog[PROG_WORDS - 1] = 32'h0000_006f;       // JAL x0, 0 spins at the end
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;
        wait (done);
        repeat (2) @(posedge clk);
        totalErrors = errorCount + i_dut.uCoreAssert.failCount;
        $display("Run finished with %0d errors", totalErrors);
        if (totalErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the program reached its end");
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== sources.f ====
design/RiscvPkg.sv
design/CtrlIf.sv
design/ControlUnit.sv
design/ImmExtend.sv
design/RegFile.sv
design/Alu.sv
design/PcUnit.sv
design/Datapath.sv
design/RiscvCore.sv
bench/Core_assert.sv
bench/CoreChecker.sv
bench/CoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run; the status follows the search for the pass line
verilator --binary --timing --assert -f sources.f --top-module CoreTb -o coreSim \
    && ./obj_dir/coreSim | tee /dev/stderr | grep -q "Test OK" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
